// File: mix_regs_pkg.sv
/* Mixer control block register map
   Register indices, bus widths and the bank, control and status types */
package mix_regs_pkg;

    // ======================================================================
    // Sizes
    // ======================================================================
    localparam int REG_NUM         = 4;
    localparam int REG_DATA_WIDTH  = 32;
    localparam int AXIL_ADDR_WIDTH = 32;
    localparam int REG_STRB_WIDTH  = REG_DATA_WIDTH / 8;
    localparam int COUNT_WIDTH     = 16;

    // ======================================================================
    // Register indices, byte offset is index * 4
    // ======================================================================
    localparam int REG_GAIN_A = 0;  // 0x0
    localparam int REG_GAIN_B = 1;  // 0x4
    localparam int REG_CTRL   = 2;  // 0x8
    localparam int REG_STATUS = 3;  // 0xC, read only

    // Whole register set as one value
    typedef logic [REG_NUM-1:0][REG_DATA_WIDTH-1:0] reg_bank_t;

    // Control word layout
    typedef struct packed {
        logic [REG_DATA_WIDTH-2:0] rsvd;
        logic                      enable;  // Bit 0
    } mix_ctrl_t;

    // Status word, out_count in the high half
    typedef struct packed {
        logic [COUNT_WIDTH-1:0] out_count;
        logic [COUNT_WIDTH-1:0] sat_count;
    } mix_status_t;

endpackage

// File: mix_sample_pkg.sv
/* Mixer sample format
   Sample, gain and lane widths plus the stream structs of the datapath */
package mix_sample_pkg;

    localparam int SAMPLE_WIDTH = 16;  // Signed
    localparam int GAIN_WIDTH   = 16;  // Unsigned Q8.8
    localparam int GAIN_FRAC    = 8;
    localparam int LANE_WIDTH   = 24;  // Scaled sample after the shift

    localparam logic signed [SAMPLE_WIDTH-1:0] SAMPLE_MAX = 16'sh7fff;
    localparam logic signed [SAMPLE_WIDTH-1:0] SAMPLE_MIN = 16'sh8000;

    // Input stream, one pair per valid
    typedef struct packed {
        logic                           valid;
        logic signed [SAMPLE_WIDTH-1:0] sample_a;
        logic signed [SAMPLE_WIDTH-1:0] sample_b;
    } sample_pair_t;

    // One gain stage result
    typedef struct packed {
        logic                         valid;
        logic signed [LANE_WIDTH-1:0] value;
    } lane_t;

    // Mixer output
    typedef struct packed {
        logic                           valid;
        logic signed [SAMPLE_WIDTH-1:0] sample;
    } mix_out_t;

endpackage

// File: axil_if.sv
/* AXI4-Lite bus with clock and reset, slave and master views */
`timescale 1ns/1ps

interface axil_if #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) (
    input logic clk_i,
    input logic rstn_i
);

    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // Write address / data / response
    logic [ADDR_WIDTH-1:0] awaddr;
    logic [2:0]            awprot;
    logic                  awvalid;
    logic                  awready;
    logic [DATA_WIDTH-1:0] wdata;
    logic [STRB_WIDTH-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;

    // Read address / data
    logic [ADDR_WIDTH-1:0] araddr;
    logic [2:0]            arprot;
    logic                  arvalid;
    logic                  arready;
    logic [DATA_WIDTH-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;

    modport slave (
        input  clk_i, rstn_i,
        input  awaddr, awprot, awvalid, output awready,
        input  wdata, wstrb, wvalid, output wready,
        output bresp, bvalid, input bready,
        input  araddr, arprot, arvalid, output arready,
        output rdata, rresp, rvalid, input rready
    );

    modport master (
        input  clk_i, rstn_i,
        output awaddr, awprot, awvalid, input awready,
        output wdata, wstrb, wvalid, input wready,
        input  bresp, bvalid, output bready,
        output araddr, arprot, arvalid, input arready,
        input  rdata, rresp, rvalid, output rready
    );

endinterface

// File: axil_reg_file.sv
/* AXI4-Lite register bank with a write-side copy driving the design
   and a read-side copy captured from it that answers reads */
`timescale 1ns/1ps

module axil_reg_file #(
    parameter type  reg_t    = mix_regs_pkg::reg_bank_t,
    parameter reg_t REG_INIT = '0
) (
    input  reg_t                           rd_regs_i,
    input  logic [mix_regs_pkg::REG_NUM-1:0] rd_valid_i,

    output reg_t                           wr_regs_o,
    output logic [mix_regs_pkg::REG_NUM-1:0] wr_valid_o,

    axil_if.slave s_axil
);

    localparam int REG_NUM  = mix_regs_pkg::REG_NUM;
    localparam int DW       = mix_regs_pkg::REG_DATA_WIDTH;
    localparam int STRB_W   = mix_regs_pkg::REG_STRB_WIDTH;
    localparam int ADDR_LSB = $clog2(STRB_W);
    localparam int ADDR_MSB = ADDR_LSB + $clog2(REG_NUM) - 1;

    typedef logic [REG_NUM-1:0][DW-1:0] bank_arr_t;

    localparam bank_arr_t REG_INIT_ARR = bank_arr_t'(REG_INIT);

    logic                  clk_i;
    logic                  rstn_i;
    bank_arr_t             wr_reg;
    bank_arr_t             rd_reg;
    bank_arr_t             rd_cap;
    logic [REG_NUM-1:0]    wr_valid;
    logic [REG_NUM-1:0]    rd_valid;
    logic                  write_valid;
    logic                  wr_handshake;
    logic [ADDR_MSB-ADDR_LSB:0] wr_idx;
    logic [ADDR_MSB-ADDR_LSB:0] rd_idx;

    assign clk_i  = s_axil.clk_i;
    assign rstn_i = s_axil.rstn_i;

    assign write_valid  = s_axil.awvalid & s_axil.wvalid;
    assign wr_handshake = write_valid & s_axil.awready & s_axil.wready;
    assign wr_idx       = s_axil.awaddr[ADDR_MSB:ADDR_LSB];
    assign rd_idx       = s_axil.araddr[ADDR_MSB:ADDR_LSB];

    // Output and input staging, one cycle each
    always_ff @(posedge clk_i) begin
        wr_regs_o  <= reg_t'(wr_reg);
        wr_valid_o <= wr_valid;
        rd_cap     <= bank_arr_t'(rd_regs_i);
        rd_valid   <= rd_valid_i;
    end

    // ======================================================================
    // Write channel
    // ======================================================================
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_reg   <= REG_INIT_ARR;
            wr_valid <= '0;
        end else begin
            wr_valid <= '0;  // Single-cycle pulse
            if (wr_handshake) begin
                for (int i = 0; i < STRB_W; i++) begin
                    if (s_axil.wstrb[i]) begin
                        wr_reg[wr_idx][i*8+:8] <= s_axil.wdata[i*8+:8];
                    end
                end
                wr_valid[wr_idx] <= 1'b1;
            end
        end
    end

    // AWREADY and WREADY pulse together
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            s_axil.awready <= 1'b0;
            s_axil.wready  <= 1'b0;
        end else begin
            s_axil.awready <= write_valid & ~s_axil.awready;
            s_axil.wready  <= write_valid & ~s_axil.wready;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            s_axil.bvalid <= 1'b0;
            s_axil.bresp  <= 2'b00;
        end else if (wr_handshake) begin
            s_axil.bvalid <= 1'b1;
            s_axil.bresp  <= 2'b00;  // Always OKAY
        end else if (s_axil.bvalid & s_axil.bready) begin
            s_axil.bvalid <= 1'b0;
        end
    end

    // ======================================================================
    // Read side bank and read channel
    // ======================================================================
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rd_reg <= REG_INIT_ARR;
        end else begin
            for (int r = 0; r < REG_NUM; r++) begin
                if (rd_valid[r]) begin
                    rd_reg[r] <= rd_cap[r];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_axil.arvalid) begin
            s_axil.rdata <= rd_reg[rd_idx];
            s_axil.rresp <= 2'b00;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            s_axil.arready <= 1'b0;
            s_axil.rvalid  <= 1'b0;
        end else begin
            s_axil.arready <= s_axil.arvalid & ~s_axil.arready;
            if (s_axil.arvalid) begin
                s_axil.rvalid <= 1'b1;
            end else if (s_axil.rvalid & s_axil.rready) begin
                s_axil.rvalid <= 1'b0;
            end
        end
    end

    // Response held until the host takes it
    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        s_axil.bvalid && !s_axil.bready |=> s_axil.bvalid);

    a_awready_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        s_axil.awready |=> !s_axil.awready);

endmodule

// File: mix_gain_stage.sv
/* One channel gain stage
   Signed sample times Q8.8 gain, shifted back to a registered lane value */
`timescale 1ns/1ps

module mix_gain_stage (
    input  logic                                        clk_i,
    input  logic                                        rstn_i,
    input  logic signed [mix_sample_pkg::SAMPLE_WIDTH-1:0] sample_i,
    input  logic                                        valid_i,
    input  logic [mix_sample_pkg::GAIN_WIDTH-1:0]       gain_i,
    output mix_sample_pkg::lane_t                       lane_o
);

    localparam int SW      = mix_sample_pkg::SAMPLE_WIDTH;
    localparam int GW      = mix_sample_pkg::GAIN_WIDTH;
    localparam int LW      = mix_sample_pkg::LANE_WIDTH;
    localparam int FRAC    = mix_sample_pkg::GAIN_FRAC;
    localparam int PROD_W  = SW + GW + 1;

    logic signed [GW:0]       gain_s;
    logic signed [PROD_W-1:0] product;
    logic                     lane_valid;
    logic signed [LW-1:0]     lane_value;

    assign gain_s  = signed'({1'b0, gain_i});  // Gain is unsigned
    assign product = sample_i * gain_s;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            lane_valid <= 1'b0;
        end else begin
            lane_valid <= valid_i;
        end
    end

    // Arithmetic shift by FRAC, fits the lane without overflow
    always_ff @(posedge clk_i) begin
        lane_value <= product[FRAC +: LW];
    end

    assign lane_o = '{valid: lane_valid, value: lane_value};

    a_valid_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !$isunknown(lane_o.valid));

endmodule

// File: mix_sum_sat.sv
/* Summing stage
   Adds both lanes, clamps to the sample range and counts outputs and clamps */
`timescale 1ns/1ps

module mix_sum_sat (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  mix_sample_pkg::lane_t         lane_a_i,
    input  mix_sample_pkg::lane_t         lane_b_i,
    input  logic                          enable_i,
    output mix_sample_pkg::mix_out_t      mix_o,
    output mix_regs_pkg::mix_status_t     status_o
);

    localparam int SW = mix_sample_pkg::SAMPLE_WIDTH;
    localparam int LW = mix_sample_pkg::LANE_WIDTH;
    localparam int CW = mix_regs_pkg::COUNT_WIDTH;

    logic signed [LW:0]    sum;
    logic signed [SW-1:0]  clamped;
    logic                  clip;
    logic                  take;
    logic                  mix_valid;
    logic signed [SW-1:0]  mix_sample;
    logic [CW-1:0]         sat_count;
    logic [CW-1:0]         out_count;

    assign sum  = lane_a_i.value + lane_b_i.value;
    assign take = enable_i & lane_a_i.valid;  // Dropped while disabled

    always_comb begin
        clip    = 1'b1;
        clamped = mix_sample_pkg::SAMPLE_MAX;
        if (sum > (LW+1)'(mix_sample_pkg::SAMPLE_MAX)) begin
            clamped = mix_sample_pkg::SAMPLE_MAX;
        end else if (sum < (LW+1)'(mix_sample_pkg::SAMPLE_MIN)) begin
            clamped = mix_sample_pkg::SAMPLE_MIN;
        end else begin
            clip    = 1'b0;
            clamped = sum[SW-1:0];
        end
    end

    // ======================================================================
    // Output register and counters, same edge
    // ======================================================================
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            mix_valid <= 1'b0;
            sat_count <= '0;
            out_count <= '0;
        end else begin
            mix_valid <= take;
            if (take) begin
                out_count <= out_count + 1'b1;  // Wraps
                if (clip) begin
                    sat_count <= sat_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            mix_sample <= clamped;
        end
    end

    assign mix_o    = '{valid: mix_valid, sample: mix_sample};
    assign status_o = '{out_count: out_count, sat_count: sat_count};

    // Both gain stages see the same input valid
    a_lanes_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
        lane_a_i.valid == lane_b_i.valid);

endmodule

// File: audio_mixer_top.sv
/* Two-channel audio mixer with AXI4-Lite control
   Register file, two gain stages and the summing stage */
`timescale 1ns/1ps

module audio_mixer_top (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    axil_if.slave                         s_axil,
    input  mix_sample_pkg::sample_pair_t  pair_i,
    output mix_sample_pkg::mix_out_t      mix_o
);

    localparam int GW = mix_sample_pkg::GAIN_WIDTH;

    mix_regs_pkg::reg_bank_t                 wr_regs;
    mix_regs_pkg::reg_bank_t                 rd_regs;
    logic [mix_regs_pkg::REG_NUM-1:0]        wr_valid;
    logic [mix_regs_pkg::REG_NUM-1:0]        rd_valid;
    mix_regs_pkg::mix_ctrl_t                 ctrl;
    mix_regs_pkg::mix_status_t               status;
    mix_sample_pkg::lane_t                   lane_a;
    mix_sample_pkg::lane_t                   lane_b;

    // Config words read back as written, status always live
    always_comb begin
        rd_regs                           = wr_regs;
        rd_regs[mix_regs_pkg::REG_STATUS] = status;
        rd_valid                          = wr_valid;
        rd_valid[mix_regs_pkg::REG_STATUS] = 1'b1;
    end

    assign ctrl = mix_regs_pkg::mix_ctrl_t'(wr_regs[mix_regs_pkg::REG_CTRL]);

    axil_reg_file #(
        .reg_t    (mix_regs_pkg::reg_bank_t),
        .REG_INIT ('0)
    ) u_regs (
        .rd_regs_i  (rd_regs),
        .rd_valid_i (rd_valid),
        .wr_regs_o  (wr_regs),
        .wr_valid_o (wr_valid),
        .s_axil     (s_axil)
    );

    mix_gain_stage u_gain_a (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .sample_i (pair_i.sample_a),
        .valid_i  (pair_i.valid),
        .gain_i   (wr_regs[mix_regs_pkg::REG_GAIN_A][GW-1:0]),
        .lane_o   (lane_a)
    );

    mix_gain_stage u_gain_b (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .sample_i (pair_i.sample_b),
        .valid_i  (pair_i.valid),
        .gain_i   (wr_regs[mix_regs_pkg::REG_GAIN_B][GW-1:0]),
        .lane_o   (lane_b)
    );

    mix_sum_sat u_sum (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .lane_a_i (lane_a),
        .lane_b_i (lane_b),
        .enable_i (ctrl.enable),
        .mix_o    (mix_o),
        .status_o (status)
    );

endmodule

// File: tb_audio_mixer.sv
/* Audio mixer testbench
   AXI4-Lite host tasks, file-driven sample stream and a scoreboard on the mix output */
`timescale 1ns/1ps

module tb_audio_mixer;

    localparam int AW      = mix_regs_pkg::AXIL_ADDR_WIDTH;
    localparam int DW      = mix_regs_pkg::REG_DATA_WIDTH;
    localparam int TIMEOUT = 200;  // Cycles per wait

    logic                         clk_i = 1'b0;
    logic                         rstn_i;
    mix_sample_pkg::sample_pair_t pair;
    mix_sample_pkg::mix_out_t     mix;

    mix_sample_pkg::mix_out_t     exp_q[$];
    int                           due_q[$];
    mix_regs_pkg::mix_status_t    model_status;
    logic [DW-1:0]                reg_model [mix_regs_pkg::REG_NUM];
    logic [15:0]                  lfsr = 16'd65;
    int                           cycle = 0;
    int                           due;
    int                           errors = 0;
    int                           errors_seen = 0;
    int                           pass_tests = 0;
    int                           fail_tests = 0;

    axil_if #(.ADDR_WIDTH(AW), .DATA_WIDTH(DW)) host_bus (.clk_i(clk_i), .rstn_i(rstn_i));

    audio_mixer_top u_dut (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .s_axil (host_bus),
        .pair_i (pair),
        .mix_o  (mix)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    // ======================================================================
    // Compare tasks and helpers
    // ======================================================================
    task automatic check_word(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_mix(input mix_sample_pkg::mix_out_t got,
                             input mix_sample_pkg::mix_out_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: mix output %0d (valid %b), expected %0d",
                     $time, got.sample, got.valid, exp.sample);
        end
    endtask

    task automatic check_status(input mix_regs_pkg::mix_status_t got,
                                input mix_regs_pkg::mix_status_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: status sat %0d out %0d, expected sat %0d out %0d",
                     $time, got.sat_count, got.out_count, exp.sat_count, exp.out_count);
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic end_test(input string name);
        if (errors == errors_seen) begin
            pass_tests++;
            $display("PASS  %s", name);
        end else begin
            fail_tests++;
            $display("FAIL  %s", name);
        end
        errors_seen = errors;
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic take_random(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    // ======================================================================
    // AXI4-Lite host
    // ======================================================================
    task automatic axil_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                              input logic [3:0] strb);
        int t;
        int delay;
        @(negedge clk_i);
        host_bus.awaddr  = addr;
        host_bus.wdata   = data;
        host_bus.wstrb   = strb;
        host_bus.awvalid = 1'b1;
        host_bus.wvalid  = 1'b1;
        t = 0;
        while (!(host_bus.awready && host_bus.wready)) begin
            @(negedge clk_i);
            t++;
            if (t > TIMEOUT) abort_run("Write address and data were never accepted");
        end
        @(negedge clk_i);  // Handshake edge has passed
        host_bus.awvalid = 1'b0;
        host_bus.wvalid  = 1'b0;
        t = 0;
        while (!host_bus.bvalid) begin
            @(negedge clk_i);
            t++;
            if (t > TIMEOUT) abort_run("Write response never arrived");
        end
        take_random(2, delay);
        repeat (delay) @(negedge clk_i);  // BREADY held low
        check_word(DW'(host_bus.bresp), '0, "write response code");
        host_bus.bready = 1'b1;
        @(negedge clk_i);
        host_bus.bready = 1'b0;
        if (host_bus.bvalid) begin
            errors++;
            $display("Write response was still valid after it was accepted at %0t", $time);
        end
    endtask

    task automatic axil_read(input logic [AW-1:0] addr, output logic [DW-1:0] data);
        int t;
        int delay;
        @(negedge clk_i);
        host_bus.araddr  = addr;
        host_bus.arvalid = 1'b1;
        t = 0;
        while (!host_bus.arready) begin
            @(negedge clk_i);
            t++;
            if (t > TIMEOUT) abort_run("Read address was never accepted");
        end
        host_bus.arvalid = 1'b0;
        t = 0;
        while (!host_bus.rvalid) begin
            @(negedge clk_i);
            t++;
            if (t > TIMEOUT) abort_run("Read data never arrived");
        end
        take_random(2, delay);
        repeat (delay) @(negedge clk_i);  // RREADY held low
        data = host_bus.rdata;
        check_word(DW'(host_bus.rresp), '0, "read response code");
        host_bus.rready = 1'b1;
        @(negedge clk_i);
        host_bus.rready = 1'b0;
        if (host_bus.rvalid) begin
            errors++;
            $display("Read data was still valid after it was accepted at %0t", $time);
        end
    endtask

    // ======================================================================
    // Vector handling
    // ======================================================================
    task automatic run_write(input int line_no, input string line);
        int            addr;
        int            data;
        int            strb;
        int            exp;
        logic [1:0]    idx;
        logic [DW-1:0] rd;
        if ($sscanf(line, "W %h %h %h %h", addr, data, strb, exp) != 4) begin
            errors++;
            $display("Line %0d of the vector file could not be parsed", line_no);
        end else begin
            idx = 2'(addr >> 2);
            axil_write(AW'(addr), DW'(data), 4'(strb));
            repeat (4) @(negedge clk_i);  // Read bank lags three cycles
            axil_read(AW'(addr), rd);
            check_word(rd, DW'(exp), $sformatf("register 0x%0h readback", addr));
            reg_model[idx] = DW'(exp);
            axil_read(AW'(mix_regs_pkg::REG_STATUS * 4), rd);
            check_status(mix_regs_pkg::mix_status_t'(rd), model_status);
        end
        end_test($sformatf("register write on line %0d", line_no));
    endtask

    task automatic drive_pair(input int a, input int b, input int e);
        longint lane_a;
        longint lane_b;
        longint sum;
        @(negedge clk_i);
        pair = '{valid: 1'b1, sample_a: 16'(a), sample_b: 16'(b)};
        if (reg_model[mix_regs_pkg::REG_CTRL][0]) begin
            lane_a = (longint'(a) * longint'(reg_model[mix_regs_pkg::REG_GAIN_A][15:0])) >>> 8;
            lane_b = (longint'(b) * longint'(reg_model[mix_regs_pkg::REG_GAIN_B][15:0])) >>> 8;
            sum    = lane_a + lane_b;
            if (sum > 32767 || sum < -32768) begin
                model_status.sat_count = model_status.sat_count + 1'b1;
            end
            model_status.out_count = model_status.out_count + 1'b1;
            exp_q.push_back('{valid: 1'b1, sample: 16'(e)});
            due_q.push_back(cycle + 2);
        end
    endtask

    task automatic finish_stream(input int line_no);
        int t;
        @(negedge clk_i);
        pair = '0;
        t = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
            t++;
            if (t > TIMEOUT) abort_run("Expected mixer outputs never appeared");
        end
        repeat (3) @(negedge clk_i);  // Catch stray outputs
        end_test($sformatf("sample stream up to line %0d", line_no));
    endtask

    // Scoreboard on the output, values settle after the rising edge
    always @(negedge clk_i) begin
        if (rstn_i && mix.valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Mixer produced an output at %0t that no sample pair called for", $time);
            end else begin
                check_mix(mix, exp_q.pop_front());
                due = due_q.pop_front();
                if (cycle != due) begin
                    errors++;
                    $display("Mixer output came at cycle %0d instead of cycle %0d", cycle, due);
                end
            end
        end
    end

    initial begin
        string         line;
        int            fd;
        int            line_no;
        int            last_s;
        int            a;
        int            b;
        int            e;
        byte           tag;
        bit            in_stream;
        logic [DW-1:0] rd;
        rstn_i = 1'b0;
        pair   = '0;
        host_bus.awaddr = '0;
        host_bus.awprot = '0;
        host_bus.awvalid = 1'b0;
        host_bus.wdata  = '0;
        host_bus.wstrb  = '0;
        host_bus.wvalid = 1'b0;
        host_bus.bready = 1'b0;
        host_bus.araddr = '0;
        host_bus.arprot = '0;
        host_bus.arvalid = 1'b0;
        host_bus.rready = 1'b0;
        model_status = '0;
        reg_model    = '{default: '0};
        line_no      = 0;
        last_s       = 0;
        in_stream    = 1'b0;
        repeat (8) @(negedge clk_i);
        rstn_i = 1'b1;
        repeat (2) @(negedge clk_i);

        for (int r = 0; r < mix_regs_pkg::REG_NUM; r++) begin
            axil_read(AW'(r * 4), rd);
            check_word(rd, '0, $sformatf("reset value of register %0d", r));
        end
        end_test("register values after reset");

        fd = $fopen("mixer_input.txt", "r");
        if (fd == 0) abort_run("Could not open the vector file mixer_input.txt");
        while ($fgets(line, fd) != 0) begin
            line_no++;
            tag = (line.len() > 1) ? line.getc(0) : "#";
            if (tag == "S" && $sscanf(line, "S %d %d %d", a, b, e) == 3) begin
                drive_pair(a, b, e);
                in_stream = 1'b1;
                last_s    = line_no;
            end else if (tag == "W") begin
                if (in_stream) finish_stream(last_s);
                in_stream = 1'b0;
                run_write(line_no, line);
            end else if (tag != "#") begin
                errors++;
                $display("Line %0d of the vector file has an unknown form", line_no);
            end
        end
        $fclose(fd);
        if (in_stream) finish_stream(last_s);

        repeat (4) @(negedge clk_i);  // Status reaches the read bank
        axil_read(AW'(mix_regs_pkg::REG_STATUS * 4), rd);
        check_status(mix_regs_pkg::mix_status_t'(rd), model_status);
        end_test("final status counts");

        $display("Tests: %0d passed, %0d failed, %0d check errors",
                 pass_tests, fail_tests, errors);
        if (fail_tests == 0 && errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: mixer_input.txt
# W addr data strb expected_readback, all hex
# S sample_a sample_b expected_mix, all signed decimal
S 1000 2000 0
S -500 300 0
W 0 00000100 f 00000100
W 4 12345678 f 12345678
W 4 00000080 3 12340080
W 8 00000001 1 00000001
S 1000 2000 2000
S -1000 -3 -1002
S 20000 20000 30000
S 30000 10000 32767
S -30000 -10000 -32768
S 32767 1 32767
S -32768 -1 -32768
W 0 00000200 3 00000200
S 100 -7 196
S 16384 0 32767
S -16384 -1 -32768
S 5 5 12
W 8 00000000 1 00000000
S 7 7 0

// File: sources.f
mix_regs_pkg.sv
mix_sample_pkg.sv
axil_if.sv
axil_reg_file.sv
mix_gain_stage.sv
mix_sum_sat.sv
audio_mixer_top.sv
tb_audio_mixer.sv

// File: run_sim.sh
#!/bin/sh
# Build the audio mixer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_audio_mixer \
    -f sources.f -o tb_audio_mixer
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_audio_mixer)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1
